/* hw/vic_timing_pkg.sv */
package vic_timing_pkg;

    // ------------------------------
    // chip selection
    // ------------------------------

    // encodings match the config pins of the original board
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6569R5   = 2'd1,
        CHIP_6567R56A = 2'd2,
        CHIP_6569R1   = 2'd3
    } chip_t;

    // beam counter widths
    localparam int RASTER_X_W = 10;
    localparam int RASTER_Y_W = 9;

    // last pixel of a line, 8 pixels per PHI cycle
    localparam logic [RASTER_X_W-1:0] RASTER_X_MAX_R8   = 10'd519;
    localparam logic [RASTER_X_W-1:0] RASTER_X_MAX_R56A = 10'd511;
    localparam logic [RASTER_X_W-1:0] RASTER_X_MAX_PAL  = 10'd503;

    // last line of a frame
    localparam logic [RASTER_Y_W-1:0] RASTER_Y_MAX_R8   = 9'd262;
    localparam logic [RASTER_Y_W-1:0] RASTER_Y_MAX_R56A = 9'd261;
    localparam logic [RASTER_Y_W-1:0] RASTER_Y_MAX_PAL  = 9'd311;

    // ------------------------------
    // phase positions
    // ------------------------------

    // dot4x ticks per PHI half phase and per pixel
    localparam int PHASE_TICKS = 16;
    localparam int PIXEL_TICKS = 4;

    // indices into the one-hot phase_start vector
    localparam int PHASE_EVAL = 1;
    localparam int PHASE_IRQ  = 8;
    localparam int PHASE_LAST = 15;

    // badlines only happen inside [first, end)
    localparam logic [RASTER_Y_W-1:0] BADLINE_FIRST = 9'd48;
    localparam logic [RASTER_Y_W-1:0] BADLINE_END   = 9'd248;

    // char fetch BA window, in cycle numbers (raster_x / 8)
    localparam logic [RASTER_X_W-4:0] BA_CHAR_FIRST = 7'd12;
    localparam logic [RASTER_X_W-4:0] BA_CHAR_LAST  = 7'd54;

    // cpu keeps its PHI-high phases for this many cycles after BA falls
    localparam int AEC_DELAY_CYCLES = 3;

    function automatic logic [RASTER_X_W-1:0] raster_x_max_of(chip_t chip);
        case (chip)
            CHIP_6567R8:   return RASTER_X_MAX_R8;
            CHIP_6567R56A: return RASTER_X_MAX_R56A;
            default:       return RASTER_X_MAX_PAL;
        endcase
    endfunction

    function automatic logic [RASTER_Y_W-1:0] raster_y_max_of(chip_t chip);
        case (chip)
            CHIP_6567R8:   return RASTER_Y_MAX_R8;
            CHIP_6567R56A: return RASTER_Y_MAX_R56A;
            default:       return RASTER_Y_MAX_PAL;
        endcase
    endfunction

endpackage

/* hw/beam_if.sv */
`timescale 1ns/1ps

interface beam_if import vic_timing_pkg::*; ();

    // current beam position
    logic [RASTER_X_W-1:0] raster_x;
    logic [RASTER_Y_W-1:0] raster_line;
    // line as seen by the irq compare, lags by about one PHI cycle
    logic [RASTER_Y_W-1:0] raster_line_d;
    // high on the first dot4x tick of every pixel
    logic                  pixel_tick;

    modport source (
        output raster_x, raster_line, raster_line_d, pixel_tick
    );

    modport sink (
        input raster_x, raster_line, raster_line_d, pixel_tick
    );

endinterface

/* hw/phase_gen.sv */
`timescale 1ns/1ps

module phase_gen import vic_timing_pkg::*; (
    input  logic                   clk_dot4x,
    input  logic                   rst,
    output logic                   clk_phi_o,
    output logic [PHASE_TICKS-1:0] phase_start_o,
    output logic                   pixel_first_o
);

    // one full PHI period, bit 0 is the phi level for this tick
    logic [2*PHASE_TICKS-1:0] phi_gen;
    // one-hot position inside the current half phase
    logic [PHASE_TICKS-1:0]   phase_pos;
    // one-hot position inside the current pixel
    logic [PIXEL_TICKS-1:0]   pixel_pos;

    // ------------------------------
    // shifters
    // ------------------------------

    // reset pattern gives 16 low ticks first, then 16 high
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_gen <= {{(PHASE_TICKS-1){1'b0}}, {PHASE_TICKS{1'b1}}, 1'b0};
        end else begin
            phi_gen <= {phi_gen[2*PHASE_TICKS-2:0], phi_gen[2*PHASE_TICKS-1]};
        end
    end

    // index 0 is the first tick after a phi edge
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_pos <= {{(PHASE_TICKS-1){1'b0}}, 1'b1};
            pixel_pos <= {{(PIXEL_TICKS-1){1'b0}}, 1'b1};
        end else begin
            phase_pos <= {phase_pos[PHASE_TICKS-2:0], phase_pos[PHASE_TICKS-1]};
            pixel_pos <= {pixel_pos[PIXEL_TICKS-2:0], pixel_pos[PIXEL_TICKS-1]};
        end
    end

    assign clk_phi_o     = phi_gen[0];
    assign phase_start_o = phase_pos;
    // pixel boundaries line up with phase index 0
    assign pixel_first_o = pixel_pos[0];

endmodule

/* hw/raster_counter.sv */
`timescale 1ns/1ps

module raster_counter import vic_timing_pkg::*; (
    input  logic                   clk_dot4x,
    input  logic                   rst,
    input  chip_t                  chip_i,
    input  logic                   pixel_first_i,
    input  logic [PHASE_TICKS-1:0] phase_start_i,
    beam_if.source                 beam
);

    logic [RASTER_X_W-1:0] x_max;
    logic [RASTER_Y_W-1:0] y_max;
    logic [RASTER_X_W-1:0] raster_x;
    logic [RASTER_Y_W-1:0] raster_line;
    logic [RASTER_Y_W-1:0] raster_line_d;
    logic                  pixel_last;

    assign x_max = raster_x_max_of(chip_i);
    assign y_max = raster_y_max_of(chip_i);

    // last tick of a pixel is the tick before each pixel boundary
    always_comb begin
        pixel_last = 1'b0;
        for (int i = PIXEL_TICKS - 1; i < PHASE_TICKS; i += PIXEL_TICKS) begin
            pixel_last = pixel_last | phase_start_i[i];
        end
    end

    // ------------------------------
    // beam counters
    // ------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x    <= '0;
            raster_line <= '0;
        end else if (pixel_last) begin
            if (raster_x == x_max) begin
                raster_x <= '0;
                // line steps together with the x wrap
                if (raster_line == y_max)
                    raster_line <= '0;
                else
                    raster_line <= raster_line + 9'd1;
            end else begin
                raster_x <= raster_x + 10'd1;
            end
        end
    end

    // delayed line copy
    // raster_x[2] is low during the PHI-low half of a cycle, so this
    // samples once per cycle at the badline evaluation point
    // readers at that same tick still see the previous line
    always_ff @(posedge clk_dot4x) begin
        if (rst)
            raster_line_d <= '0;
        else if (phase_start_i[PHASE_EVAL] && !raster_x[2])
            raster_line_d <= raster_line;
    end

    assign beam.raster_x      = raster_x;
    assign beam.raster_line   = raster_line;
    assign beam.raster_line_d = raster_line_d;
    assign beam.pixel_tick    = pixel_first_i;

endmodule

/* hw/badline_detect.sv */
`timescale 1ns/1ps

module badline_detect import vic_timing_pkg::*; (
    input  logic                   clk_dot4x,
    input  logic                   rst,
    beam_if.sink                   beam,
    input  logic                   clk_phi_i,
    input  logic [PHASE_TICKS-1:0] phase_start_i,
    input  logic                   den_i,
    input  logic [2:0]             yscroll_i,
    output logic                   badline_o
);

    logic [RASTER_X_W-4:0] cycle_num;
    logic                  allow_bad_lines;
    logic                  allow_next;
    logic                  eval;

    assign cycle_num = beam.raster_x[RASTER_X_W-1:3];
    // once per cycle, early in the low phase
    assign eval = !clk_phi_i && phase_start_i[PHASE_EVAL];

    // den counts anywhere on line 48
    // cycle 0 of 48 is seen through raster_line, the rest through the
    // delayed copy, which also catches den set in the very last cycle
    always_comb begin
        allow_next = allow_bad_lines;
        if (den_i && ((beam.raster_line == BADLINE_FIRST && cycle_num == '0) ||
                      beam.raster_line_d == BADLINE_FIRST))
            allow_next = 1'b1;
        if (beam.raster_line == BADLINE_END)
            allow_next = 1'b0;
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline_o       <= 1'b0;
        end else if (eval) begin
            allow_bad_lines <= allow_next;
            badline_o       <= allow_next &&
                               beam.raster_line >= BADLINE_FIRST &&
                               beam.raster_line < BADLINE_END &&
                               beam.raster_line[2:0] == yscroll_i;
        end
    end

endmodule

/* hw/raster_irq.sv */
`timescale 1ns/1ps

module raster_irq import vic_timing_pkg::*; (
    input  logic                   clk_dot4x,
    input  logic                   rst,
    beam_if.sink                   beam,
    input  logic                   clk_phi_i,
    input  logic [PHASE_TICKS-1:0] phase_start_i,
    input  logic [RASTER_Y_W-1:0]  compare_i,
    input  logic                   erst_i,
    input  logic                   irst_clr_i,
    output logic                   irq_o
);

    logic [RASTER_Y_W-1:0] compare_d;
    // raw interrupt latch, independent of the enable
    logic                  irst;
    // line already fired, blocks a second set on the same line
    logic                  triggered;
    logic                  fire_point;

    // compare value taken on pixel boundaries
    always_ff @(posedge clk_dot4x) begin
        if (beam.pixel_tick)
            compare_d <= compare_i;
    end

    assign fire_point = !clk_phi_i && phase_start_i[PHASE_IRQ];

    // ------------------------------
    // latch
    // ------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst      <= 1'b0;
            triggered <= 1'b0;
        end else begin
            if (beam.raster_line_d == compare_d) begin
                if (fire_point && !triggered) begin
                    triggered <= 1'b1;
                    irst      <= 1'b1;
                end
            end else begin
                // new line, arm again
                triggered <= 1'b0;
            end
            // clear wins over a set in the same tick
            if (irst_clr_i)
                irst <= 1'b0;
        end
    end

    // enabling erst later exposes an already pending latch at once
    assign irq_o = irst & erst_i;

endmodule

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import vic_timing_pkg::*; (
    input  logic                   clk_dot4x,
    beam_if.sink                   beam,
    input  logic                   clk_phi_i,
    input  logic [PHASE_TICKS-1:0] phase_start_i,
    input  logic                   badline_i,
    output logic                   ba_o,
    output logic                   aec_o
);

    logic [RASTER_X_W-4:0]     cycle_num;
    logic                      ba_chars;
    // ba history sampled at the end of each PHI-high phase
    logic [AEC_DELAY_CYCLES-1:0] ba_pipe;

    assign cycle_num = beam.raster_x[RASTER_X_W-1:3];

    // ------------------------------
    // BA
    // ------------------------------

    // low while the char fetch window is open on a badline
    assign ba_chars = !(badline_i &&
                        cycle_num >= BA_CHAR_FIRST &&
                        cycle_num <= BA_CHAR_LAST);

    always_ff @(posedge clk_dot4x) begin
        ba_o <= ba_chars;
    end

    // ------------------------------
    // AEC cascade
    // ------------------------------

    // last stage only drops after ba has been low for
    // AEC_DELAY_CYCLES high phases
    always_ff @(posedge clk_dot4x) begin
        if (clk_phi_i && phase_start_i[PHASE_LAST]) begin
            ba_pipe[0] <= ba_o;
            for (int k = 1; k < AEC_DELAY_CYCLES; k++) begin
                ba_pipe[k] <= ba_pipe[k-1] | ba_o;
            end
        end
    end

    // aec low hands the bus to the vic
    // cpu owns PHI high unless the cascade has run out
    always_ff @(posedge clk_dot4x) begin
        if (ba_o)
            aec_o <= clk_phi_i;
        else
            aec_o <= ba_pipe[AEC_DELAY_CYCLES-1] & clk_phi_i;
    end

endmodule

/* hw/vic_timing_top.sv */
`timescale 1ns/1ps

module vic_timing_top import vic_timing_pkg::*; (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  logic [1:0]            chip_i,
    input  logic                  den_i,
    input  logic [2:0]            yscroll_i,
    input  logic [RASTER_Y_W-1:0] raster_irq_compare_i,
    input  logic                  erst_i,
    input  logic                  irst_clr_i,
    output logic                  clk_phi_o,
    output logic [RASTER_X_W-1:0] raster_x_o,
    output logic [RASTER_Y_W-1:0] raster_line_o,
    output logic                  badline_o,
    output logic                  irq_o,
    output logic                  ba_o,
    output logic                  aec_o
);

    chip_t                  chip;
    logic                   clk_phi;
    logic [PHASE_TICKS-1:0] phase_start;
    logic                   pixel_first;
    logic                   badline;

    beam_if beam ();

    assign chip = chip_t'(chip_i);

    // ------------------------------
    // timing chain
    // ------------------------------
    phase_gen phase_gen_inst (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .clk_phi_o     (clk_phi),
        .phase_start_o (phase_start),
        .pixel_first_o (pixel_first)
    );

    raster_counter raster_counter_inst (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .chip_i        (chip),
        .pixel_first_i (pixel_first),
        .phase_start_i (phase_start),
        .beam          (beam.source)
    );

    badline_detect badline_detect_inst (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .beam          (beam.sink),
        .clk_phi_i     (clk_phi),
        .phase_start_i (phase_start),
        .den_i         (den_i),
        .yscroll_i     (yscroll_i),
        .badline_o     (badline)
    );

    raster_irq raster_irq_inst (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .beam          (beam.sink),
        .clk_phi_i     (clk_phi),
        .phase_start_i (phase_start),
        .compare_i     (raster_irq_compare_i),
        .erst_i        (erst_i),
        .irst_clr_i    (irst_clr_i),
        .irq_o         (irq_o)
    );

    // BA and AEC toward the cpu bus
    bus_arbiter bus_arbiter_inst (
        .clk_dot4x     (clk_dot4x),
        .beam          (beam.sink),
        .clk_phi_i     (clk_phi),
        .phase_start_i (phase_start),
        .badline_i     (badline),
        .ba_o          (ba_o),
        .aec_o         (aec_o)
    );

    assign clk_phi_o     = clk_phi;
    assign raster_x_o    = beam.raster_x;
    assign raster_line_o = beam.raster_line;
    assign badline_o     = badline;

endmodule

/* bench/vic_timing_checker.sv */
`timescale 1ns/1ps

module vic_timing_checker import vic_timing_pkg::*; (
    input logic                  clk_dot4x,
    input logic                  rst,
    input logic [1:0]            chip_i,
    input logic                  clk_phi_i,
    input logic [RASTER_X_W-1:0] raster_x_i,
    input logic                  erst_i,
    input logic                  irq_i,
    input logic                  aec_i
);

    // count of failed assertions
    int assert_errors = 0;

    // ------------------------------
    // bus and beam rules
    // ------------------------------

    // aec lags phi by one tick so two low ticks force it low
    aec_low_in_phi_low: assert property (@(posedge clk_dot4x) disable iff (rst)
        (!clk_phi_i && !$past(clk_phi_i)) |-> !aec_i)
    else begin
        $error("aec high after two phi low ticks");
        assert_errors++;
    end

    raster_x_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
        raster_x_i <= raster_x_max_of(chip_t'(chip_i)))
    else begin
        $error("raster x beyond the chip maximum");
        assert_errors++;
    end

    // irq output is gated by the enable
    irq_needs_erst: assert property (@(posedge clk_dot4x) disable iff (rst)
        irq_i |-> erst_i)
    else begin
        $error("irq high with erst low");
        assert_errors++;
    end

endmodule

/* bench/vic_timing_tb.sv */
`timescale 1ns/1ps

module vic_timing_tb import vic_timing_pkg::*; ();

    localparam int NUM_VECTORS = 5;
    localparam int STIM_COLS   = 8;
    localparam int CYCLE_TICKS = 2 * PHASE_TICKS;
    // clear pulse lands in cycle 10 of its line
    localparam int CLEAR_POS   = 10 * CYCLE_TICKS;

    logic                  clk_dot4x;
    logic                  rst;
    logic [1:0]            chip_i;
    logic                  den_i;
    logic [2:0]            yscroll_i;
    logic [RASTER_Y_W-1:0] raster_irq_compare_i;
    logic                  erst_i;
    logic                  irst_clr_i;
    logic                  clk_phi_o;
    logic [RASTER_X_W-1:0] raster_x_o;
    logic [RASTER_Y_W-1:0] raster_line_o;
    logic                  badline_o;
    logic                  irq_o;
    logic                  ba_o;
    logic                  aec_o;

    // eight words per vector in the column order of the stim file
    logic [15:0] stim_mem [0:NUM_VECTORS*STIM_COLS-1];

    // fields of the vector in flight
    int x_max;
    int y_max;
    int line_ticks;
    int frame_ticks;
    int yscroll;
    int compare_line;
    int clear_line;
    bit den;
    bit erst;
    // model of the raw interrupt latch
    bit irq_pend;
    int cycle_count   = 0;
    int timeout_limit = 0;

    vic_timing_top vic_timing_top_inst (.*);

    bind vic_timing_top vic_timing_checker checker_inst (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .chip_i     (chip_i),
        .clk_phi_i  (clk_phi_o),
        .raster_x_i (raster_x_o),
        .erst_i     (erst_i),
        .irq_i      (irq_o),
        .aec_i      (aec_o)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #4 clk_dot4x = ~clk_dot4x;
    end

    // ------------------------------
    // watchdog
    // ------------------------------
    always @(posedge clk_dot4x) begin
        cycle_count = cycle_count + 1;
        if (vic_timing_top_inst.checker_inst.assert_errors != 0) begin
            $display("assertion failure reported by the checker");
            $display("** FAIL **");
            $fatal(1, "stopping at first assertion failure");
        end
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            $display("timeout: no end of run after %0d clock cycles", timeout_limit);
            $display("** FAIL **");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic int line_of(input int t);
        return (t / line_ticks) % (y_max + 1);
    endfunction

    function automatic bit is_badline(input int line_num);
        return den && line_num >= BADLINE_FIRST && line_num < BADLINE_END &&
               (line_num % 8) == yscroll;
    endfunction

    // irst_clr is high for exactly one tick per frame
    function automatic bit clear_at(input int t);
        return line_of(t) == clear_line && (t % line_ticks) == CLEAR_POS;
    endfunction

    task automatic load_vector(input int v);
        int base;
        base         = v * STIM_COLS;
        den          = stim_mem[base+1][0];
        yscroll      = stim_mem[base+2][2:0];
        compare_line = stim_mem[base+3];
        erst         = stim_mem[base+4][0];
        clear_line   = stim_mem[base+5];
        x_max        = stim_mem[base+6];
        y_max        = stim_mem[base+7];
        line_ticks   = (x_max + 1) * PIXEL_TICKS;
        frame_ticks  = line_ticks * (y_max + 1);
        chip_i               = stim_mem[base][1:0];
        den_i                = den;
        yscroll_i            = yscroll;
        raster_irq_compare_i = compare_line;
        erst_i               = erst;
        irst_clr_i           = 1'b0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(posedge clk_dot4x);
        #1;
        rst      = 1'b0;
        irq_pend = 1'b0;
    endtask

    // ------------------------------
    // per tick expectations
    // ------------------------------
    task automatic check_tick(input int t);
        int  line_num;
        int  p;
        int  cyc;
        int  tk;
        bit  bad;
        bit  ba_low;
        line_num = line_of(t);
        p        = t % line_ticks;
        cyc      = p / CYCLE_TICKS;
        tk       = p % CYCLE_TICKS;
        bad      = is_badline(line_num);
        check_value("clk_phi_o", clk_phi_o, tk >= PHASE_TICKS);
        check_value("raster_x_o", raster_x_o, p / PIXEL_TICKS);
        check_value("raster_line_o", raster_line_o, line_num);
        // badline settles inside cycle 0
        if (cyc >= 1)
            check_value("badline_o", badline_o, bad);
        check_value("irq_o", irq_o, irq_pend && erst);
        // char window of cycles 12..54 seen one tick late
        ba_low = bad && p > BA_CHAR_FIRST * CYCLE_TICKS &&
                 p <= (BA_CHAR_LAST + 1) * CYCLE_TICKS;
        check_value("ba_o", ba_o, !ba_low);
        // middle of each half phase
        if (tk == PHASE_TICKS / 2)
            check_value("aec_o", aec_o, 0);
        else if (tk == PHASE_TICKS + PHASE_TICKS / 2)
            check_value("aec_o", aec_o, !(bad && cyc >= BA_CHAR_FIRST + AEC_DELAY_CYCLES &&
                                          cyc <= BA_CHAR_LAST));
        // latch for the next tick
        // clear beats set
        if (clear_at(t))
            irq_pend = 1'b0;
        else if (line_num == compare_line && p == PHASE_IRQ)
            irq_pend = 1'b1;
    endtask

    // one frame plus one cycle so the line wrap is seen too
    task automatic run_frame();
        int t;
        for (t = 0; t < frame_ticks + CYCLE_TICKS; t++) begin
            @(negedge clk_dot4x);
            check_tick(t);
            @(posedge clk_dot4x);
            #1;
            irst_clr_i = clear_at(t + 1);
        end
    endtask

    initial begin
        int v;
        int total;
        rst                  = 1'b1;
        chip_i               = 2'd0;
        den_i                = 1'b0;
        yscroll_i            = 3'd0;
        raster_irq_compare_i = '0;
        erst_i               = 1'b0;
        irst_clr_i           = 1'b0;
        $readmemh("bench/vic_timing_stim.txt", stim_mem);
        // frame length of every vector plus 10%
        total = 0;
        for (v = 0; v < NUM_VECTORS; v++)
            total += PIXEL_TICKS * (stim_mem[v*STIM_COLS+6] + 1) * (stim_mem[v*STIM_COLS+7] + 1);
        timeout_limit = total + total / 10;
        for (v = 0; v < NUM_VECTORS; v++) begin
            load_vector(v);
            apply_reset();
            run_frame();
        end
        if (vic_timing_top_inst.checker_inst.assert_errors == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "assertion failures in the checker");
        end
    end

endmodule

/* bench/vic_timing_stim.txt */
// chip den yscroll compare erst clear_line x_max y_max, all hex
// chip 0 6567R8, 1 6569R5, 2 6567R56A, 3 6569R1
0 1 3 033 1 040 207 106
1 1 0 12c 1 12c 1f7 137
2 1 7 064 0 070 1ff 105
3 0 3 030 1 030 1f7 137
1 1 5 0f8 1 130 1f7 137

/* flist.f */
hw/vic_timing_pkg.sv
hw/beam_if.sv
hw/phase_gen.sv
hw/raster_counter.sv
hw/badline_detect.sv
hw/raster_irq.sv
hw/bus_arbiter.sv
hw/vic_timing_top.sv
bench/vic_timing_checker.sv
bench/vic_timing_tb.sv
